// File: design/icache_pkg.sv
package icache_pkg;

  // Bus and word widths
  localparam int ADDR_W   = 32;
  localparam int INST_W   = 32;
  localparam int BEAT_W   = 64;

  // Line geometry
  localparam int LINE_W   = 128;
  localparam int OFFSET_W = 4;   // 16 bytes per line
  localparam int BEATS    = 4;

  // Associativity
  localparam int WAYS     = 8;
  localparam int WAY_W    = 3;

  // Tag field sized for the single-set case
  // Shorter tags are zero-extended into it
  localparam int TAG_FIELD_W = ADDR_W - OFFSET_W;

  typedef logic [LINE_W-1:0] line_t;

  typedef struct packed {
    logic                   valid;
    logic [TAG_FIELD_W-1:0] tag;
  } tag_entry_t;

  // Index width for a given set count and never below one bit
  function automatic int clog2_sets(input int sets);
    return (sets > 1) ? $clog2(sets) : 1;
  endfunction

endpackage

// File: design/icache_way_ram.sv
module icache_way_ram import icache_pkg::*; #(
  parameter type entry_t  = line_t,
  parameter int  NUM_SETS = 16
) (
  input  logic                              clock_i,
  input  logic                              reset_i,
  input  logic [clog2_sets(NUM_SETS)-1:0]   rindex_i,
  input  logic                              wen_i,
  input  logic [clog2_sets(NUM_SETS)-1:0]   windex_i,
  input  logic [WAY_W-1:0]                  wway_i,
  input  entry_t                            wentry_i,
  output entry_t [WAYS-1:0]                 rentries_o
);

  // True for the tag store only
  localparam bit CLEAR_ON_RESET = ($bits(entry_t) == $bits(tag_entry_t));

  entry_t mem [NUM_SETS][WAYS];

  //--------------------------------------------------------------------
  // Write port writes one way of one set per cycle
  //--------------------------------------------------------------------
  always_ff @(posedge clock_i) begin
    if (CLEAR_ON_RESET && reset_i) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
          mem[s][w] <= '0;
        end
      end
    end else if (wen_i) begin
      mem[windex_i][wway_i] <= wentry_i;
    end
  end

  //--------------------------------------------------------------------
  // Read port returns all ways of the set after one cycle
  //--------------------------------------------------------------------
  always_ff @(posedge clock_i) begin
    for (int w = 0; w < WAYS; w++) begin
      rentries_o[w] <= mem[rindex_i][w];  // Old contents on a same-cycle write
    end
  end

endmodule

// File: design/icache_lookup.sv
module icache_lookup import icache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic                              clock_i,
  input  logic                              reset_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  logic [ADDR_W-1:0]                 req_pc_i,
  output logic [clog2_sets(NUM_SETS)-1:0]   rindex_o,
  input  tag_entry_t [WAYS-1:0]             tags_i,
  input  line_t [WAYS-1:0]                  lines_i,
  output logic                              lk_valid_o,
  input  logic                              lk_ready_i,
  output logic [ADDR_W-1:0]                 lk_pc_o,
  output logic                              lk_hit_o,
  output line_t                             lk_line_o,
  output logic [WAYS-1:0]                   lk_valid_mask_o,
  input  logic                              wen_i,
  input  logic [clog2_sets(NUM_SETS)-1:0]   windex_i
);

  localparam int IDX_W = clog2_sets(NUM_SETS);

  logic              full_q;    // Slot holds a request
  logic              rd_ok_q;   // Array output belongs to the held set and is current
  logic [ADDR_W-1:0] pc_q;
  logic              accept;
  logic              take;
  logic [TAG_FIELD_W-1:0] req_tag;
  logic [WAYS-1:0]   hit_vec;

  assign take        = lk_valid_o && lk_ready_i;
  assign req_ready_o = !full_q || take;
  assign accept      = req_valid_i && req_ready_o;

  // Incoming request gets the read port and the held one re-reads otherwise
  assign rindex_o = accept ? req_pc_i[OFFSET_W +: IDX_W] : pc_q[OFFSET_W +: IDX_W];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      full_q  <= 1'b0;
      rd_ok_q <= 1'b0;
    end else begin
      if (accept) begin
        full_q <= 1'b1;
      end else if (take) begin
        full_q <= 1'b0;
      end
      rd_ok_q <= !(wen_i && (windex_i == rindex_o)); // Stale read is replayed next cycle
    end
  end

  always_ff @(posedge clock_i) begin
    if (accept) begin
      pc_q <= req_pc_i;
    end
  end

  //--------------------------------------------------------------------
  // Tag compare and way select
  //--------------------------------------------------------------------
  assign req_tag = TAG_FIELD_W'(pc_q[ADDR_W-1:OFFSET_W+IDX_W]);

  always_comb begin
    lk_line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w]         = tags_i[w].valid && (tags_i[w].tag == req_tag);
      lk_valid_mask_o[w] = tags_i[w].valid;
      if (hit_vec[w]) begin
        lk_line_o = lk_line_o | lines_i[w];  // At most one way hits
      end
    end
  end

  assign lk_valid_o = full_q && rd_ok_q;
  assign lk_pc_o    = pc_q;
  assign lk_hit_o   = |hit_vec;

endmodule

// File: design/icache_refill_ctrl.sv
module icache_refill_ctrl import icache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic                              clock_i,
  input  logic                              reset_i,

  input  logic                              lk_valid_i,
  output logic                              lk_ready_o,
  input  logic [ADDR_W-1:0]                 lk_pc_i,
  input  logic                              lk_hit_i,
  input  line_t                             lk_line_i,
  input  logic [WAYS-1:0]                   lk_valid_mask_i,

  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic [ADDR_W-1:0]                 rsp_pc_o,
  output logic [INST_W-1:0]                 rsp_inst_o,

  output logic                              wen_o,
  output logic [clog2_sets(NUM_SETS)-1:0]   windex_o,
  output logic [WAY_W-1:0]                  wway_o,
  output tag_entry_t                        wtag_o,
  output line_t                             wline_o,

  // AR channel
  output logic                              axi_arvalid_o,
  input  logic                              axi_arready_i,
  output logic [ADDR_W-1:0]                 axi_araddr_o,
  output logic [3:0]                        axi_arid_o,
  output logic [7:0]                        axi_arlen_o,
  output logic [2:0]                        axi_arsize_o,
  output logic [1:0]                        axi_arburst_o,

  // R channel
  input  logic                              axi_rvalid_i,
  output logic                              axi_rready_o,
  input  logic [BEAT_W-1:0]                 axi_rdata_i,
  input  logic [1:0]                        axi_rresp_i,  // Not checked
  input  logic                              axi_rlast_i,
  input  logic [3:0]                        axi_rid_i     // Not checked
);

  localparam int IDX_W = clog2_sets(NUM_SETS);
  localparam int CNT_W = $clog2(BEATS);

  typedef enum logic [2:0] {
    IDLE, WAIT_ARREADY, WAIT_RVALID, WAIT_READY, READ_END
  } state_t;

  state_t            state_q, state_d;
  logic [ADDR_W-1:0] pc_q;
  line_t             line_q;
  logic [WAYS-1:0]   vmask_q;
  logic [CNT_W-1:0]  beat_q;
  logic [7:0]        lfsr_q;
  logic [WAY_W-1:0]  victim;
  logic              accept;
  logic              ar_hs;
  logic              r_hs;

  assign accept = lk_valid_i && lk_ready_o;
  assign ar_hs  = axi_arvalid_o && axi_arready_i;
  assign r_hs   = axi_rvalid_i && axi_rready_o;

  //--------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:         if (lk_valid_i) state_d = lk_hit_i ? WAIT_READY : WAIT_ARREADY;
      WAIT_ARREADY: if (axi_arready_i) state_d = WAIT_RVALID;
      WAIT_RVALID:  if (r_hs && axi_rlast_i) state_d = READ_END;
      WAIT_READY,
      READ_END:     if (rsp_ready_i) state_d = IDLE;
      default:      state_d = IDLE;
    endcase
  end

  // Request capture followed by beats in line order
  always_ff @(posedge clock_i) begin
    if (accept) begin
      pc_q    <= lk_pc_i;
      line_q  <= lk_line_i;
      vmask_q <= lk_valid_mask_i;
    end else if (r_hs) begin
      // 32-bit beats sit on the lane picked by address bit 2
      line_q[beat_q*INST_W +: INST_W] <= beat_q[0] ? axi_rdata_i[BEAT_W-1:INST_W]
                                                   : axi_rdata_i[INST_W-1:0];
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      beat_q <= '0;
      lfsr_q <= 8'h01;
    end else begin
      if (r_hs) begin
        beat_q <= axi_rlast_i ? '0 : beat_q + 1'b1;
      end
      if (ar_hs) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

  //--------------------------------------------------------------------
  // Victim choice takes the lowest invalid way first
  //--------------------------------------------------------------------
  always_comb begin
    victim = lfsr_q[WAY_W-1:0];
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!vmask_q[w]) begin
        victim = WAY_W'(w);
      end
    end
  end

  // Outputs
  assign lk_ready_o  = (state_q == IDLE);
  assign rsp_valid_o = (state_q == WAIT_READY) || (state_q == READ_END);
  assign rsp_pc_o    = pc_q;
  assign rsp_inst_o  = (pc_q[1:0] != 2'b00) ? '0
                     : line_q[pc_q[OFFSET_W-1:2]*INST_W +: INST_W];

  assign wen_o      = (state_q == READ_END) && rsp_ready_i;  // Write as the response leaves
  assign windex_o   = pc_q[OFFSET_W +: IDX_W];
  assign wway_o     = victim;
  assign wtag_o     = '{valid: 1'b1, tag: TAG_FIELD_W'(pc_q[ADDR_W-1:OFFSET_W+IDX_W])};
  assign wline_o    = line_q;

  assign axi_arvalid_o = (state_q == WAIT_ARREADY);
  assign axi_araddr_o  = {pc_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // Line aligned
  assign axi_arid_o    = 4'd0;
  assign axi_arlen_o   = 8'(BEATS - 1);
  assign axi_arsize_o  = 3'b010;   // 4 bytes per beat
  assign axi_arburst_o = 2'b01;    // INCR
  assign axi_rready_o  = (state_q == WAIT_RVALID);

endmodule

// File: design/icache_top.sv
module icache_top import icache_pkg::*; #(
  parameter int NUM_SETS = 16
) (
  input  logic              clock_i,
  input  logic              reset_i,

  // Fetch request
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [ADDR_W-1:0] req_pc_i,

  // Fetch response
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [ADDR_W-1:0] rsp_pc_o,
  output logic [INST_W-1:0] rsp_inst_o,

  // AXI read master
  output logic              axi_arvalid_o,
  input  logic              axi_arready_i,
  output logic [ADDR_W-1:0] axi_araddr_o,
  output logic [3:0]        axi_arid_o,
  output logic [7:0]        axi_arlen_o,
  output logic [2:0]        axi_arsize_o,
  output logic [1:0]        axi_arburst_o,
  input  logic              axi_rvalid_i,
  output logic              axi_rready_o,
  input  logic [BEAT_W-1:0] axi_rdata_i,
  input  logic [1:0]        axi_rresp_i,
  input  logic              axi_rlast_i,
  input  logic [3:0]        axi_rid_i
);

  localparam int IDX_W = clog2_sets(NUM_SETS);

  //--------------------------------------------------------------------
  // Lookup to control
  //--------------------------------------------------------------------
  logic              lk_valid;
  logic              lk_ready;
  logic [ADDR_W-1:0] lk_pc;
  logic              lk_hit;
  line_t             lk_line;
  logic [WAYS-1:0]   lk_valid_mask;

  // Array ports
  logic [IDX_W-1:0]     rindex;
  tag_entry_t [WAYS-1:0] tag_rd;
  line_t [WAYS-1:0]     line_rd;
  logic                 wen;
  logic [IDX_W-1:0]     windex;
  logic [WAY_W-1:0]     wway;
  tag_entry_t           wtag;
  line_t                wline;

  icache_lookup #(.NUM_SETS(NUM_SETS)) u_lookup (
    .clock_i         (clock_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_pc_i        (req_pc_i),
    .rindex_o        (rindex),
    .tags_i          (tag_rd),
    .lines_i         (line_rd),
    .lk_valid_o      (lk_valid),
    .lk_ready_i      (lk_ready),
    .lk_pc_o         (lk_pc),
    .lk_hit_o        (lk_hit),
    .lk_line_o       (lk_line),
    .lk_valid_mask_o (lk_valid_mask),
    .wen_i           (wen),
    .windex_i        (windex)
  );

  icache_refill_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
    .clock_i         (clock_i),
    .reset_i         (reset_i),
    .lk_valid_i      (lk_valid),
    .lk_ready_o      (lk_ready),
    .lk_pc_i         (lk_pc),
    .lk_hit_i        (lk_hit),
    .lk_line_i       (lk_line),
    .lk_valid_mask_i (lk_valid_mask),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_pc_o        (rsp_pc_o),
    .rsp_inst_o      (rsp_inst_o),
    .wen_o           (wen),
    .windex_o        (windex),
    .wway_o          (wway),
    .wtag_o          (wtag),
    .wline_o         (wline),
    .axi_arvalid_o   (axi_arvalid_o),
    .axi_arready_i   (axi_arready_i),
    .axi_araddr_o    (axi_araddr_o),
    .axi_arid_o      (axi_arid_o),
    .axi_arlen_o     (axi_arlen_o),
    .axi_arsize_o    (axi_arsize_o),
    .axi_arburst_o   (axi_arburst_o),
    .axi_rvalid_i    (axi_rvalid_i),
    .axi_rready_o    (axi_rready_o),
    .axi_rdata_i     (axi_rdata_i),
    .axi_rresp_i     (axi_rresp_i),
    .axi_rlast_i     (axi_rlast_i),
    .axi_rid_i       (axi_rid_i)
  );

  // Tag store with valid bits cleared by reset
  icache_way_ram #(.entry_t(tag_entry_t), .NUM_SETS(NUM_SETS)) u_tags (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .rindex_i   (rindex),
    .wen_i      (wen),
    .windex_i   (windex),
    .wway_i     (wway),
    .wentry_i   (wtag),
    .rentries_o (tag_rd)
  );

  icache_way_ram #(.entry_t(line_t), .NUM_SETS(NUM_SETS)) u_data (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .rindex_i   (rindex),
    .wen_i      (wen),
    .windex_i   (windex),
    .wway_i     (wway),
    .wentry_i   (wline),
    .rentries_o (line_rd)
  );

endmodule

// File: tests/icache_asserts.sv
module icache_asserts (
  input logic        clock_i,
  input logic        reset_i,
  input logic        arvalid_i,
  input logic        arready_i,
  input logic [31:0] araddr_i,
  input logic [7:0]  arlen_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic        rlast_i,
  input logic        rsp_valid_i,
  input logic        rsp_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;
  logic        in_burst;  // Between AR handshake and last beat

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      in_burst <= 1'b0;
    end else if (arvalid_i && arready_i) begin
      in_burst <= 1'b1;
    end else if (rvalid_i && rready_i && rlast_i) begin
      in_burst <= 1'b0;
    end
  end

  //----------------------------------------------------------------------
  // AR channel
  //----------------------------------------------------------------------
  ar_stable: assert property (@(posedge clock_i) disable iff (reset_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      $error("AR request dropped or changed before arready");
      fail_count++;
    end

  ar_len: assert property (@(posedge clock_i) disable iff (reset_i)
    arvalid_i |-> arlen_i == 8'd3)
    else begin
      $error("Burst length is not four beats");
      fail_count++;
    end

  r_in_burst: assert property (@(posedge clock_i) disable iff (reset_i)
    rready_i |-> in_burst)
    else begin
      $error("rready high with no burst open");
      fail_count++;
    end

  // Response side
  rsp_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i)
    else begin
      $error("Response withdrawn before rsp_ready");
      fail_count++;
    end

endmodule

// File: tests/icache_mem_model.sv
module icache_mem_model import icache_pkg::*; #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic              clock_i,
  input  logic              reset_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic [7:0]        arlen_i,
  output logic              rvalid_o,
  input  logic              rready_i,
  output logic [BEAT_W-1:0] rdata_o,
  output logic [1:0]        rresp_o,
  output logic              rlast_o,
  output logic [3:0]        rid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] rng;

  // Memory image word at byte address a
  function automatic logic [31:0] mix_word(input logic [31:0] a);
    logic [31:0] x;
    x = a;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic random_pause();
    rng = mix_word(rng);
    repeat (rng[1:0]) @(negedge clock_i);  // 0 to 3 cycles
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [31:0]       word;
    rng       = SEED;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = 2'b00;
    rlast_o   = 1'b0;
    rid_o     = 4'd0;
    forever begin
      @(negedge clock_i);
      if (!reset_i && arvalid_i) begin
        addr = araddr_i;
        len  = arlen_i;
        random_pause();
        arready_o = 1'b1;
        @(negedge clock_i);
        arready_o = 1'b0;
        //------------------------------------------------------------------
        // Data beats carry the 32-bit word on the lane picked by address bit 2
        //------------------------------------------------------------------
        for (int k = 0; k <= int'(len); k++) begin
          random_pause();
          word     = mix_word(addr);
          rdata_o  = addr[2] ? {word, ~word} : {~word, word};  // Other lane is noise
          rlast_o  = (k == int'(len));
          rvalid_o = 1'b1;
          while (!rready_i) @(negedge clock_i);
          @(negedge clock_i);
          rvalid_o = 1'b0;
          rlast_o  = 1'b0;
          addr     = addr + 4;
        end
      end
    end
  end

endmodule

// File: tests/icache_tb.sv
module icache_tb import icache_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'hc6e8_9281;
  localparam int N_REQ       = 16 + 16 + 200 + 72 + 3;
  localparam int RESET_CYC   = 16;
  localparam int WATCHDOG_NS = (N_REQ * 200 + RESET_CYC) * 4;

  logic              clock = 1'b0;
  logic              reset;
  logic              req_valid;
  logic              req_ready;
  logic [ADDR_W-1:0] req_pc;
  logic              rsp_valid;
  logic              rsp_ready;
  logic [ADDR_W-1:0] rsp_pc;
  logic [INST_W-1:0] rsp_inst;
  logic              arvalid, arready, rvalid, rready, rlast;
  logic [ADDR_W-1:0] araddr;
  logic [3:0]        arid, rid;
  logic [7:0]        arlen;
  logic [2:0]        arsize;
  logic [1:0]        arburst, rresp;
  logic [BEAT_W-1:0] rdata;

  logic [ADDR_W-1:0] pending[$];  // Accepted pcs in order
  logic [31:0]       rng;
  logic [31:0]       rdy_rng;
  logic              bp_on = 1'b0;
  int                errors = 0;
  int                checks = 0;
  int                ar_count = 0;
  int                rsp_count = 0;
  int                issued = 0;

  always #2 clock = ~clock;

  icache_top #(.NUM_SETS(16)) i_dut (
    .clock_i(clock), .reset_i(reset),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_pc_i(req_pc),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_pc_o(rsp_pc),
    .rsp_inst_o(rsp_inst),
    .axi_arvalid_o(arvalid), .axi_arready_i(arready), .axi_araddr_o(araddr),
    .axi_arid_o(arid), .axi_arlen_o(arlen), .axi_arsize_o(arsize),
    .axi_arburst_o(arburst), .axi_rvalid_i(rvalid), .axi_rready_o(rready),
    .axi_rdata_i(rdata), .axi_rresp_i(rresp), .axi_rlast_i(rlast), .axi_rid_i(rid)
  );

  icache_mem_model #(.SEED(SEED ^ 32'h5a5a_0f0f)) u_mem (
    .clock_i(clock), .reset_i(reset),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
    .rlast_o(rlast), .rid_o(rid)
  );

  bind icache_refill_ctrl icache_asserts u_asserts (
    .clock_i(clock_i), .reset_i(reset_i),
    .arvalid_i(axi_arvalid_o), .arready_i(axi_arready_i), .araddr_i(axi_araddr_o),
    .arlen_i(axi_arlen_o), .rvalid_i(axi_rvalid_i), .rready_i(axi_rready_o),
    .rlast_i(axi_rlast_i), .rsp_valid_i(rsp_valid_o), .rsp_ready_i(rsp_ready_i)
  );

  //----------------------------------------------------------------------
  // Reference model
  //----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] exp_inst(input logic [31:0] pc);
    return (pc[1:0] != 2'b00) ? 32'h0 : xorshift32(pc);  // Memory word is xorshift of address
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Compare process sampling mid low phase
  always begin
    logic [31:0] exp_pc;
    @(negedge clock);
    #1;
    if (!reset) begin
      if (rsp_valid && rsp_ready) begin
        rsp_count++;
        if (pending.size() == 0) begin
          errors++;
          $display("A response arrived with no request outstanding at %0d ns", $time);
        end else begin
          exp_pc = pending.pop_front();
          check_value("response pc", rsp_pc, exp_pc);
          check_value("instruction", rsp_inst, exp_inst(exp_pc));
        end
      end
      if (req_valid && req_ready) pending.push_back(req_pc);
      if (arvalid && arready) begin
        ar_count++;
        check_value("burst address offset", {28'h0, araddr[3:0]}, 32'h0);
        check_value("burst length", {24'h0, arlen}, 32'd3);
        check_value("burst id", {28'h0, arid}, 32'h0);
        check_value("burst size", {29'h0, arsize}, 32'd2);   // 4-byte beats
        check_value("burst type", {30'h0, arburst}, 32'd1);  // INCR
      end
    end
  end

  // Response back-pressure
  always begin
    @(negedge clock);
    if (bp_on) begin
      rdy_rng   = xorshift32(rdy_rng);
      rsp_ready = rdy_rng[0] | rdy_rng[1];
    end else begin
      rsp_ready = 1'b1;
    end
  end

  task automatic send_req(input logic [31:0] pc);
    req_valid = 1'b1;
    req_pc    = pc;
    #1;
    while (!req_ready) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    req_valid = 1'b0;
    issued++;
  endtask

  task automatic drain();
    while (pending.size() != 0) @(negedge clock);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------
  initial begin
    int e0;
    int ar0;
    int rsp0;
    rng       = SEED;
    rdy_rng   = SEED ^ 32'h1357_9bdf;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_pc    = '0;
    rsp_ready = 1'b1;
    repeat (RESET_CYC) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    e0  = errors;
    ar0 = ar_count;
    for (int i = 0; i < 16; i++) send_req(32'h0000_1000 + 4 * i);
    drain();
    check_value("cold miss bursts", ar_count - ar0, 4);
    report_test("cold_misses", e0);

    e0  = errors;
    ar0 = ar_count;
    for (int i = 0; i < 16; i++) begin
      rng = xorshift32(rng);
      send_req(32'h0000_1000 + {rng[3:0], 2'b00});
    end
    drain();
    check_value("bursts on hits", ar_count - ar0, 0);
    report_test("hits", e0);

    e0    = errors;
    rsp0  = rsp_count;
    bp_on = 1'b1;
    for (int i = 0; i < 200; i++) begin
      rng = xorshift32(rng);
      send_req(32'h0002_0000 + {rng[9:2], 2'b00});
    end
    drain();
    bp_on = 1'b0;
    check_value("responses under back-pressure", rsp_count - rsp0, 200);
    report_test("back_pressure", e0);

    e0  = errors;
    ar0 = ar_count;
    for (int k = 0; k < 12; k++) send_req(32'h0004_0050 + k * 32'h100);
    for (int i = 0; i < 60; i++) begin
      rng = xorshift32(rng);
      send_req(32'h0004_0050 + (rng[15:8] % 12) * 32'h100 + {rng[1:0], 2'b00});
    end
    drain();
    check_value("at least 12 bursts in one set", 32'(ar_count - ar0 >= 12), 1);
    report_test("replacement", e0);

    e0  = errors;
    ar0 = ar_count;
    send_req(32'h0008_0040);
    send_req(32'h0008_0044);
    send_req(32'h0008_0046);  // Misaligned
    drain();
    check_value("bursts for one line", ar_count - ar0, 1);
    report_test("same_line", e0);

    $display("tests 5, requests %0d, checks %0d, errors %0d, assertion failures %0d",
             issued, checks, errors, i_dut.u_ctrl.u_asserts.fail_count);
    if (errors == 0 && i_dut.u_ctrl.u_asserts.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the cache stopped answering before all requests completed");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: icache_top.f
design/icache_pkg.sv
design/icache_way_ram.sv
design/icache_lookup.sv
design/icache_refill_ctrl.sv
design/icache_top.sv
tests/icache_asserts.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = icache_tb
FILELIST  = icache_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
